//--- include/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Datapath and address width
`define CORE_XLEN 32

// Word-addressed instruction memory
`define CORE_IMEM_WORDS 64
`define CORE_IMEM_AW 6

// Word-addressed data memory
`define CORE_DMEM_WORDS 64
`define CORE_DMEM_AW 6

// Number of architectural registers
`define CORE_NREGS 32

// ADDI x0,x0,0
`define CORE_NOP 32'h0000_0013

`endif

//--- rtl/core_pkg.sv
package core_pkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // ALU operations
    // Loads, stores and ADDI all use ALU_ADD for the address or sum
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

endpackage

//--- rtl/stage_fetch.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module stage_fetch (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      imem_we,
    input  logic [`CORE_IMEM_AW-1:0]  imem_addr,
    input  logic [`CORE_XLEN-1:0]     imem_wdata,
    input  logic                      branch_taken,
    input  logic [`CORE_XLEN-1:0]     branch_target,
    output logic [`CORE_XLEN-1:0]     if_pc,
    output logic [`CORE_XLEN-1:0]     if_inst
);

    logic [`CORE_XLEN-1:0] imem [`CORE_IMEM_WORDS];
    logic [`CORE_XLEN-1:0] pc;
    logic [`CORE_IMEM_AW-1:0] pc_word;
    logic [`CORE_XLEN-1:0] fetched;

    // Byte PC to word index
    assign pc_word = pc[`CORE_IMEM_AW+1:2];
    assign fetched = imem[pc_word];

    // Program load port is open only while the core is held in reset
    always_ff @(posedge clk) begin
        if (rst && imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    // Program counter
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (branch_taken) begin
            pc <= branch_target;
        end else begin
            pc <= pc + `CORE_XLEN'd4;
        end
    end

    // IF/ID register
    // A taken branch squashes the word fetched this cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            if_pc   <= '0;
            if_inst <= `CORE_NOP;
        end else begin
            if_pc   <= pc;
            if_inst <= branch_taken ? `CORE_NOP : fetched;
        end
    end

endmodule

//--- rtl/stage_decode.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module stage_decode (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`CORE_XLEN-1:0] if_pc,
    input  logic [`CORE_XLEN-1:0] if_inst,
    input  logic                  branch_taken,
    input  logic [`CORE_XLEN-1:0] wb_data,
    input  logic [4:0]            wb_rd,
    input  logic                  wb_reg_write,
    input  logic [4:0]            dbg_reg,
    output logic [`CORE_XLEN-1:0] dbg_data,
    output logic [`CORE_XLEN-1:0] id_pc,
    output logic [`CORE_XLEN-1:0] id_rs1_data,
    output logic [`CORE_XLEN-1:0] id_rs2_data,
    output logic [`CORE_XLEN-1:0] id_imm,
    output logic [4:0]            id_rd,
    output core_pkg::alu_op_e     id_alu_op,
    output logic                  id_alu_src,
    output logic                  id_mem_read,
    output logic                  id_mem_write,
    output logic                  id_branch,
    output logic                  id_branch_ne,
    output logic                  id_reg_write
);

    core_pkg::opcode_e     opcode;
    logic [4:0]            rd;
    logic [4:0]            rs1;
    logic [4:0]            rs2;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [`CORE_XLEN-1:0] imm_i;
    logic [`CORE_XLEN-1:0] imm_s;
    logic [`CORE_XLEN-1:0] imm_b;

    core_pkg::alu_op_e     dec_alu_op;
    logic [`CORE_XLEN-1:0] dec_imm;
    logic                  dec_valid;
    logic                  dec_alu_src;
    logic                  dec_mem_read;
    logic                  dec_mem_write;
    logic                  dec_branch;
    logic                  dec_reg_write;
    logic                  kill;

    logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];
    logic [`CORE_XLEN-1:0] rs1_data;
    logic [`CORE_XLEN-1:0] rs2_data;

    // Instruction fields
    assign opcode = core_pkg::opcode_e'(if_inst[6:0]);
    assign rd     = if_inst[11:7];
    assign funct3 = if_inst[14:12];
    assign rs1    = if_inst[19:15];
    assign rs2    = if_inst[24:20];
    assign funct7 = if_inst[31:25];

    // Sign-extended immediates
    assign imm_i = {{20{if_inst[31]}}, if_inst[31:20]};
    assign imm_s = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
    assign imm_b = {{19{if_inst[31]}}, if_inst[31], if_inst[7], if_inst[30:25],
                    if_inst[11:8], 1'b0};

    always_comb begin
        dec_alu_op    = core_pkg::ALU_ADD;
        dec_imm       = imm_i;
        dec_valid     = 1'b0;
        dec_alu_src   = 1'b0;
        dec_mem_read  = 1'b0;
        dec_mem_write = 1'b0;
        dec_branch    = 1'b0;
        dec_reg_write = 1'b0;
        case (opcode)
            core_pkg::OPC_OP: begin
                // SUB is the only funct7 variant kept
                dec_valid     = (funct7 == 7'h00) || (funct7 == 7'h20 && funct3 == 3'b000);
                dec_reg_write = 1'b1;
                case (funct3)
                    3'b000:  dec_alu_op = funct7[5] ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
                    3'b010:  dec_alu_op = core_pkg::ALU_SLT;
                    3'b100:  dec_alu_op = core_pkg::ALU_XOR;
                    3'b110:  dec_alu_op = core_pkg::ALU_OR;
                    3'b111:  dec_alu_op = core_pkg::ALU_AND;
                    default: dec_valid  = 1'b0;
                endcase
            end
            core_pkg::OPC_OP_IMM: begin
                dec_valid     = (funct3 == 3'b000);
                dec_alu_src   = 1'b1;
                dec_reg_write = 1'b1;
            end
            core_pkg::OPC_LOAD: begin
                dec_valid     = (funct3 == 3'b010);
                dec_alu_src   = 1'b1;
                dec_mem_read  = 1'b1;
                dec_reg_write = 1'b1;
            end
            core_pkg::OPC_STORE: begin
                dec_valid     = (funct3 == 3'b010);
                dec_imm       = imm_s;
                dec_alu_src   = 1'b1;
                dec_mem_write = 1'b1;
            end
            core_pkg::OPC_BRANCH: begin
                // BEQ and BNE only, no register write
                dec_valid  = (funct3 == 3'b000) || (funct3 == 3'b001);
                dec_imm    = imm_b;
                dec_branch = 1'b1;
            end
            default: dec_valid = 1'b0;
        endcase
    end

    // Flushed slots arrive from fetch as NOPs and leave here as bubbles
    assign kill = branch_taken || (if_inst == `CORE_NOP) || !dec_valid;

    // Register file with x0 never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_reg_write && wb_rd != 5'd0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Write-through so a value written this cycle is read this cycle
    assign rs1_data = (wb_reg_write && wb_rd != 5'd0 && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_data = (wb_reg_write && wb_rd != 5'd0 && wb_rd == rs2) ? wb_data : regs[rs2];

    // Debug read port
    always_ff @(posedge clk) begin
        dbg_data <= regs[dbg_reg];
    end

    // ID/EX control fields
    always_ff @(posedge clk) begin
        if (rst || kill) begin
            id_alu_op    <= core_pkg::ALU_ADD;
            id_alu_src   <= 1'b0;
            id_mem_read  <= 1'b0;
            id_mem_write <= 1'b0;
            id_branch    <= 1'b0;
            id_branch_ne <= 1'b0;
            id_reg_write <= 1'b0;
        end else begin
            id_alu_op    <= dec_alu_op;
            id_alu_src   <= dec_alu_src;
            id_mem_read  <= dec_mem_read;
            id_mem_write <= dec_mem_write;
            id_branch    <= dec_branch;
            id_branch_ne <= funct3[0];
            id_reg_write <= dec_reg_write;
        end
    end

    // ID/EX data fields
    always_ff @(posedge clk) begin
        id_pc       <= if_pc;
        id_rs1_data <= rs1_data;
        id_rs2_data <= rs2_data;
        id_imm      <= dec_imm;
        id_rd       <= rd;
    end

endmodule

//--- rtl/stage_execute.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module stage_execute (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`CORE_XLEN-1:0] id_pc,
    input  logic [`CORE_XLEN-1:0] id_rs1_data,
    input  logic [`CORE_XLEN-1:0] id_rs2_data,
    input  logic [`CORE_XLEN-1:0] id_imm,
    input  logic [4:0]            id_rd,
    input  core_pkg::alu_op_e     id_alu_op,
    input  logic                  id_alu_src,
    input  logic                  id_mem_read,
    input  logic                  id_mem_write,
    input  logic                  id_branch,
    input  logic                  id_branch_ne,
    input  logic                  id_reg_write,
    output logic [`CORE_XLEN-1:0] ex_alu_out,
    output logic [`CORE_XLEN-1:0] ex_store_data,
    output logic [4:0]            ex_rd,
    output logic                  ex_mem_read,
    output logic                  ex_mem_write,
    output logic                  ex_reg_write,
    output logic                  branch_taken,
    output logic [`CORE_XLEN-1:0] branch_target
);

    logic [`CORE_XLEN-1:0] operand_a;
    logic [`CORE_XLEN-1:0] operand_b;
    logic [`CORE_XLEN-1:0] alu_result;
    logic                  operands_equal;

    assign operand_a = id_rs1_data;
    assign operand_b = id_alu_src ? id_imm : id_rs2_data;

    always_comb begin
        case (id_alu_op)
            core_pkg::ALU_ADD: alu_result = operand_a + operand_b;
            core_pkg::ALU_SUB: alu_result = operand_a - operand_b;
            core_pkg::ALU_AND: alu_result = operand_a & operand_b;
            core_pkg::ALU_OR:  alu_result = operand_a | operand_b;
            core_pkg::ALU_XOR: alu_result = operand_a ^ operand_b;
            // Signed compare
            core_pkg::ALU_SLT: begin
                alu_result = ($signed(operand_a) < $signed(operand_b)) ? `CORE_XLEN'd1 : '0;
            end
            default:           alu_result = operand_a + operand_b;
        endcase
    end

    // BNE inverts the equality test
    assign operands_equal = (id_rs1_data == id_rs2_data);
    assign branch_taken   = id_branch && (operands_equal ^ id_branch_ne);
    assign branch_target  = id_pc + id_imm;

    // EX/MEM control fields
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_reg_write <= 1'b0;
        end else begin
            ex_mem_read  <= id_mem_read;
            ex_mem_write <= id_mem_write;
            ex_reg_write <= id_reg_write;
        end
    end

    // EX/MEM data fields
    always_ff @(posedge clk) begin
        ex_alu_out    <= alu_result;
        ex_store_data <= id_rs2_data;
        ex_rd         <= id_rd;
    end

endmodule

//--- rtl/stage_memory.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module stage_memory (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`CORE_XLEN-1:0] ex_alu_out,
    input  logic [`CORE_XLEN-1:0] ex_store_data,
    input  logic [4:0]            ex_rd,
    input  logic                  ex_mem_read,
    input  logic                  ex_mem_write,
    input  logic                  ex_reg_write,
    output logic [`CORE_XLEN-1:0] wb_data,
    output logic [4:0]            wb_rd,
    output logic                  wb_reg_write
);

    logic [`CORE_XLEN-1:0]    dmem [`CORE_DMEM_WORDS];
    logic [`CORE_DMEM_AW-1:0] word_addr;
    logic [`CORE_XLEN-1:0]    load_data;

    // Word index from the byte address
    assign word_addr = ex_alu_out[`CORE_DMEM_AW+1:2];
    assign load_data = dmem[word_addr];

    // Store
    always_ff @(posedge clk) begin
        if (ex_mem_write) begin
            dmem[word_addr] <= ex_store_data;
        end
    end

    // MEM/WB write enable
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_reg_write <= 1'b0;
        end else begin
            wb_reg_write <= ex_reg_write;
        end
    end

    // MEM/WB data with the writeback value already selected
    always_ff @(posedge clk) begin
        wb_data <= ex_mem_read ? load_data : ex_alu_out;
        wb_rd   <= ex_rd;
    end

endmodule

//--- rtl/core.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module core (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     imem_we,
    input  logic [`CORE_IMEM_AW-1:0] imem_addr,
    input  logic [`CORE_XLEN-1:0]    imem_wdata,
    input  logic [4:0]               dbg_reg,
    output logic [`CORE_XLEN-1:0]    dbg_data
);

    // Fetch to decode
    logic [`CORE_XLEN-1:0] if_pc;
    logic [`CORE_XLEN-1:0] if_inst;

    // Decode to execute
    logic [`CORE_XLEN-1:0] id_pc;
    logic [`CORE_XLEN-1:0] id_rs1_data;
    logic [`CORE_XLEN-1:0] id_rs2_data;
    logic [`CORE_XLEN-1:0] id_imm;
    logic [4:0]            id_rd;
    core_pkg::alu_op_e     id_alu_op;
    logic                  id_alu_src;
    logic                  id_mem_read;
    logic                  id_mem_write;
    logic                  id_branch;
    logic                  id_branch_ne;
    logic                  id_reg_write;

    // Execute to memory
    logic [`CORE_XLEN-1:0] ex_alu_out;
    logic [`CORE_XLEN-1:0] ex_store_data;
    logic [4:0]            ex_rd;
    logic                  ex_mem_read;
    logic                  ex_mem_write;
    logic                  ex_reg_write;

    // Branch redirect back to fetch and decode
    logic                  branch_taken;
    logic [`CORE_XLEN-1:0] branch_target;

    // Writeback into the register file
    logic [`CORE_XLEN-1:0] wb_data;
    logic [4:0]            wb_rd;
    logic                  wb_reg_write;

    stage_fetch i_fetch (
        .clk           (clk),
        .rst           (rst),
        .imem_we       (imem_we),
        .imem_addr     (imem_addr),
        .imem_wdata    (imem_wdata),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .if_pc         (if_pc),
        .if_inst       (if_inst)
    );

    stage_decode i_decode (
        .clk          (clk),
        .rst          (rst),
        .if_pc        (if_pc),
        .if_inst      (if_inst),
        .branch_taken (branch_taken),
        .wb_data      (wb_data),
        .wb_rd        (wb_rd),
        .wb_reg_write (wb_reg_write),
        .dbg_reg      (dbg_reg),
        .dbg_data     (dbg_data),
        .id_pc        (id_pc),
        .id_rs1_data  (id_rs1_data),
        .id_rs2_data  (id_rs2_data),
        .id_imm       (id_imm),
        .id_rd        (id_rd),
        .id_alu_op    (id_alu_op),
        .id_alu_src   (id_alu_src),
        .id_mem_read  (id_mem_read),
        .id_mem_write (id_mem_write),
        .id_branch    (id_branch),
        .id_branch_ne (id_branch_ne),
        .id_reg_write (id_reg_write)
    );

    stage_execute i_execute (
        .clk           (clk),
        .rst           (rst),
        .id_pc         (id_pc),
        .id_rs1_data   (id_rs1_data),
        .id_rs2_data   (id_rs2_data),
        .id_imm        (id_imm),
        .id_rd         (id_rd),
        .id_alu_op     (id_alu_op),
        .id_alu_src    (id_alu_src),
        .id_mem_read   (id_mem_read),
        .id_mem_write  (id_mem_write),
        .id_branch     (id_branch),
        .id_branch_ne  (id_branch_ne),
        .id_reg_write  (id_reg_write),
        .ex_alu_out    (ex_alu_out),
        .ex_store_data (ex_store_data),
        .ex_rd         (ex_rd),
        .ex_mem_read   (ex_mem_read),
        .ex_mem_write  (ex_mem_write),
        .ex_reg_write  (ex_reg_write),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    stage_memory i_memory (
        .clk           (clk),
        .rst           (rst),
        .ex_alu_out    (ex_alu_out),
        .ex_store_data (ex_store_data),
        .ex_rd         (ex_rd),
        .ex_mem_read   (ex_mem_read),
        .ex_mem_write  (ex_mem_write),
        .ex_reg_write  (ex_reg_write),
        .wb_data       (wb_data),
        .wb_rd         (wb_rd),
        .wb_reg_write  (wb_reg_write)
    );

endmodule

//--- testbench/core_tb.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module core_tb;

    // Six tests take about 120 cycles each to load, run and read back
    localparam int max_cycles = 2000;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     imem_we;
    logic [`CORE_IMEM_AW-1:0] imem_addr;
    logic [`CORE_XLEN-1:0]    imem_wdata;
    logic [4:0]               dbg_reg;
    logic [`CORE_XLEN-1:0]    dbg_data;

    integer seed;
    int     cycle_count = 0;
    logic [`CORE_XLEN-1:0] program_words[$];

    core i_dut (
        .clk        (clk),
        .rst        (rst),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .dbg_reg    (dbg_reg),
        .dbg_data   (dbg_data)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: the run went past %0d clock cycles", max_cycles);
            $display("Test failed");
            $fatal(1, "Simulation stopped at the cycle limit");
        end
    end

    // Instruction encoders for the RV32I field layout
    function automatic logic [31:0] rtype(input logic [6:0] funct7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] funct3,
                                          input logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, core_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] funct3, input logic [4:0] rd,
                                          input core_pkg::opcode_e opc);
        return {imm, rs1, funct3, rd, opc};
    endfunction

    function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], core_pkg::OPC_STORE};
    endfunction

    function automatic logic [31:0] btype(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] funct3);
        return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], core_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return itype(imm, rs1, 3'b000, rd, core_pkg::OPC_OP_IMM);
    endfunction

    task automatic pad_nops(input int n);
        for (int i = 0; i < n; i++) begin
            program_words.push_back(`CORE_NOP);
        end
    endtask

    // Core held in reset while the whole instruction memory is written
    task automatic load_program();
        @(posedge clk);
        rst <= 1'b1;
        for (int i = 0; i < `CORE_IMEM_WORDS; i++) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= i[`CORE_IMEM_AW-1:0];
            imem_wdata <= (i < program_words.size()) ? program_words[i] : `CORE_NOP;
        end
        @(posedge clk);
        imem_we <= 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic run_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic read_reg(input logic [4:0] r, output logic [`CORE_XLEN-1:0] value);
        @(posedge clk);
        dbg_reg <= r;
        @(posedge clk);
        // Sampled mid-cycle away from the debug register update
        @(negedge clk);
        value = dbg_data;
    endtask

    task automatic check_word(input string name, input logic [`CORE_XLEN-1:0] got,
                              input logic [`CORE_XLEN-1:0] exp);
        if (got !== exp) begin
            $display("Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
            $display("Test failed");
            $fatal(1, "Register value mismatch");
        end
    endtask

    task automatic check_reg(input logic [4:0] r, input logic [`CORE_XLEN-1:0] exp);
        logic [`CORE_XLEN-1:0] value;
        read_reg(r, value);
        check_word($sformatf("x%0d", r), value, exp);
    endtask

    task automatic alu_ops();
        logic [31:0] rnd;
        logic [11:0] ia;
        logic [11:0] ib;
        logic [31:0] a;
        logic [31:0] b;
        rnd = $random(seed);
        ia  = rnd[11:0];
        rnd = $random(seed);
        ib  = rnd[11:0];
        a   = {{20{ia[11]}}, ia};
        b   = {{20{ib[11]}}, ib};
        program_words.delete();
        program_words.push_back(addi(5'd1, 5'd0, ia));
        program_words.push_back(addi(5'd2, 5'd0, ib));
        pad_nops(3);
        program_words.push_back(rtype(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        program_words.push_back(rtype(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
        program_words.push_back(rtype(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));
        program_words.push_back(rtype(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
        program_words.push_back(rtype(7'h00, 5'd2, 5'd1, 3'b100, 5'd7));
        program_words.push_back(rtype(7'h00, 5'd2, 5'd1, 3'b010, 5'd8));
        load_program();
        run_cycles(program_words.size() + 8);
        check_reg(5'd1, a);
        check_reg(5'd2, b);
        check_reg(5'd3, a + b);
        check_reg(5'd4, a - b);
        check_reg(5'd5, a & b);
        check_reg(5'd6, a | b);
        check_reg(5'd7, a ^ b);
        check_reg(5'd8, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    endtask

    task automatic x0_and_immediates();
        program_words.delete();
        program_words.push_back(addi(5'd0, 5'd0, 12'h123));
        program_words.push_back(addi(5'd5, 5'd0, 12'hffb));
        program_words.push_back(addi(5'd6, 5'd0, 12'h800));
        pad_nops(3);
        program_words.push_back(addi(5'd7, 5'd5, 12'd7));
        program_words.push_back(addi(5'd8, 5'd0, 12'd1));
        load_program();
        run_cycles(program_words.size() + 8);
        check_reg(5'd0, 32'h0000_0000);
        check_reg(5'd5, 32'hffff_fffb);
        check_reg(5'd6, 32'hffff_f800);
        check_reg(5'd7, 32'h0000_0002);
        check_reg(5'd8, 32'h0000_0001);
    endtask

    task automatic store_load_roundtrip();
        logic [31:0] rnd;
        logic [31:0] a;
        rnd = $random(seed);
        a   = {{20{rnd[11]}}, rnd[11:0]};
        program_words.delete();
        program_words.push_back(addi(5'd1, 5'd0, rnd[11:0]));
        program_words.push_back(addi(5'd2, 5'd0, 12'd8));
        pad_nops(3);
        program_words.push_back(rtype(7'h00, 5'd1, 5'd1, 3'b000, 5'd3));
        pad_nops(3);
        // Words 2 and 7 of the data memory
        program_words.push_back(stype(12'd0, 5'd3, 5'd2));
        program_words.push_back(stype(12'd20, 5'd1, 5'd2));
        pad_nops(1);
        program_words.push_back(itype(12'd0, 5'd2, 3'b010, 5'd4, core_pkg::OPC_LOAD));
        program_words.push_back(itype(12'd20, 5'd2, 3'b010, 5'd5, core_pkg::OPC_LOAD));
        load_program();
        run_cycles(program_words.size() + 8);
        check_reg(5'd4, a + a);
        check_reg(5'd5, a);
    endtask

    task automatic branch_outcomes();
        program_words.delete();
        program_words.push_back(addi(5'd1, 5'd0, 12'd5));
        program_words.push_back(addi(5'd2, 5'd0, 12'd9));
        pad_nops(3);
        // Taken BEQ skips three ADDIs and two of them are flushed
        program_words.push_back(btype(13'd16, 5'd1, 5'd1, 3'b000));
        program_words.push_back(addi(5'd10, 5'd0, 12'd1));
        program_words.push_back(addi(5'd11, 5'd0, 12'd1));
        program_words.push_back(addi(5'd12, 5'd0, 12'd1));
        // Taken BNE
        program_words.push_back(btype(13'd16, 5'd2, 5'd1, 3'b001));
        program_words.push_back(addi(5'd13, 5'd0, 12'd1));
        program_words.push_back(addi(5'd14, 5'd0, 12'd1));
        program_words.push_back(addi(5'd15, 5'd0, 12'd1));
        // Not taken BEQ and BNE
        program_words.push_back(btype(13'd8, 5'd2, 5'd1, 3'b000));
        program_words.push_back(addi(5'd16, 5'd0, 12'd1));
        program_words.push_back(btype(13'd8, 5'd1, 5'd1, 3'b001));
        program_words.push_back(addi(5'd17, 5'd0, 12'd1));
        program_words.push_back(addi(5'd18, 5'd0, 12'd7));
        load_program();
        run_cycles(program_words.size() + 8);
        for (int r = 10; r <= 15; r++) begin
            check_reg(5'(r), 32'd0);
        end
        check_reg(5'd16, 32'd1);
        check_reg(5'd17, 32'd1);
        check_reg(5'd18, 32'd7);
    endtask

    task automatic throughput_burst();
        program_words.delete();
        for (int i = 0; i < 8; i++) begin
            program_words.push_back(addi(5'(20 + i), 5'd0, 12'(i * 37 + 1)));
        end
        load_program();
        run_cycles(program_words.size() + 8);
        for (int i = 0; i < 8; i++) begin
            check_reg(5'(20 + i), 32'(i * 37 + 1));
        end
    endtask

    // Relies on x20..x27 written by the throughput test
    task automatic reset_clears_regs();
        program_words.delete();
        pad_nops(6);
        program_words.push_back(addi(5'd3, 5'd0, 12'h055));
        program_words.push_back(addi(5'd9, 5'd0, 12'hfff));
        load_program();
        check_reg(5'd20, 32'd0);
        check_reg(5'd3, 32'd0);
        run_cycles(program_words.size() + 8);
        check_reg(5'd3, 32'h0000_0055);
        check_reg(5'd9, 32'hffff_ffff);
        check_reg(5'd27, 32'd0);
    endtask

    initial begin
        rst        <= 1'b1;
        imem_we    <= 1'b0;
        imem_addr  <= '0;
        imem_wdata <= '0;
        dbg_reg    <= '0;
        seed = 32'hd087;
        alu_ops();
        x0_and_immediates();
        store_load_roundtrip();
        branch_outcomes();
        throughput_burst();
        reset_clears_regs();
        $display("Test passed");
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
rtl/core_pkg.sv
rtl/stage_fetch.sv
rtl/stage_decode.sv
rtl/stage_execute.sv
rtl/stage_memory.sv
rtl/core.sv
testbench/core_tb.sv

//--- run.sh
#!/bin/sh
# Build the core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f flist.f --top-module core_tb -o core_sim \
    && ./obj_dir/core_sim \
    || { echo "Simulation run reported a failure"; exit 1; }
